// File: hw/cacheCtrlPkg.sv
/* cache controller shared types
   address fields, way status and command bundles, miss sequencer states */
package cacheCtrlPkg;

   // byte address, tag | index | word | byte
   typedef logic [15:0] addrT;
   typedef logic [15:0] dataT;
   typedef logic [4:0]  tagT;
   typedef logic [7:0]  indexT;
   // word within a line, same number picks the memory bank
   typedef logic [1:0]  wordSelT;

   // status reported by one cache way for the presented address
   typedef struct packed {
      logic hit;
      logic valid;
      logic dirty;
      tagT  tag;
   } wayStatusT;

   // command to one cache way
   // comp=0 with write fills a word and sets the tag from the address
   typedef struct packed {
      logic enable;
      logic comp;
      logic write;
   } wayCmdT;

   // memory bus, four banks interleaved on the word field
   typedef struct packed {
      logic read;
      logic write;
      addrT addr;
      dataT wrData;
   } memCmdT;

   // wb0 and fill0 sit one past a multiple of four
   // the result stage derives the bank from that
   typedef enum logic [3:0] {
      idle   = 4'd0,
      wb0    = 4'd1,
      wb1    = 4'd2,
      wb2    = 4'd3,
      wb3    = 4'd4,
      fill0  = 4'd5,
      fill1  = 4'd6,
      fill2  = 4'd7,
      fill3  = 4'd8,
      fill4  = 4'd9,
      fill5  = 4'd10,
      access = 4'd11,
      finish = 4'd12
   } seqStateT;

   function automatic tagT tagOf(addrT a);
      return a[15:11];
   endfunction

   function automatic indexT indexOf(addrT a);
      return a[10:3];
   endfunction

   function automatic wordSelT wordOf(addrT a);
      return a[2:1];
   endfunction

   // word aligned address, byte bit always zero
   function automatic addrT makeAddr(tagT tag, indexT index, wordSelT word);
      return {tag, index, word, 1'b0};
   endfunction

endpackage

// File: hw/victimSelect.sv
/* victim select, decode stage
   classifies a request as hit, clean miss or dirty miss and picks the way */
`timescale 1ns/1ps

module victimSelect (
   input  cacheCtrlPkg::wayStatusT wayStat0,
   input  cacheCtrlPkg::wayStatusT wayStat1,
   input  logic                    victimWay,
   output logic                    hit,
   output logic                    hitWay,
   output logic                    missWay,
   output logic                    dirtyMiss
);

   import cacheCtrlPkg::*;

   logic      hitValid0;
   logic      hitValid1;
   wayStatusT victimStat;

   // a tag match only counts on a valid line
   assign hitValid0 = wayStat0.hit & wayStat0.valid;
   assign hitValid1 = wayStat1.hit & wayStat1.valid;

   assign hit = hitValid0 | hitValid1;
   // way 0 wins when both match
   assign hitWay = ~hitValid0 & hitValid1;

   // fill an empty way first, way 0 before way 1
   // with both ways in use the external victim bit decides
   always_comb
   begin
      if (!wayStat0.valid)
         missWay = 1'b0;
      else if (!wayStat1.valid)
         missWay = 1'b1;
      else
         missWay = victimWay;
   end

   assign victimStat = missWay ? wayStat1 : wayStat0;

   // only a valid dirty victim needs a writeback
   assign dirtyMiss = ~hit & victimStat.valid & victimStat.dirty;

   // the ways must never hold the same line twice
   always_comb
   begin
      assert final (!(hitValid0 && hitValid1 && (wayStat0.tag == wayStat1.tag)))
         else $error("both ways hold a valid copy of tag %h", wayStat0.tag);
   end

endmodule

// File: hw/missSequencer.sv
/* miss sequencer, execute stage
   captures a missing request and steps through writeback, fill and final access */
`timescale 1ns/1ps

module missSequencer (
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   rd,
   input  logic                   wr,
   input  logic                   stall,
   input  cacheCtrlPkg::addrT     addr,
   input  cacheCtrlPkg::dataT     dataIn,
   input  logic                   hit,
   input  logic                   dirtyMiss,
   input  logic                   missWay,
   output cacheCtrlPkg::seqStateT state,
   output cacheCtrlPkg::addrT     lineAddr,
   output cacheCtrlPkg::dataT     heldData,
   output logic                   heldWay,
   output logic                   heldWrite
);

   import cacheCtrlPkg::*;

   logic     reqValid;
   logic     accept;
   seqStateT nextState;

   // exactly one of rd and wr, stall blocks the request
   assign reqValid = (rd ^ wr) & ~stall;

   // a hit finishes in idle, only a miss starts the sequence
   assign accept = (state == idle) & reqValid & ~hit;

   always_comb
   begin
      nextState = idle;
      unique case (state)
         idle:
         begin
            // dirty victim goes out to memory before the fill
            if (accept)
               nextState = dirtyMiss ? wb0 : fill0;
            else
               nextState = idle;
         end
         // writeback, one bank per cycle
         wb0:
            nextState = wb1;
         wb1:
            nextState = wb2;
         wb2:
            nextState = wb3;
         wb3:
            nextState = fill0;
         // four bank reads, data trails by two cycles
         fill0:
            nextState = fill1;
         fill1:
            nextState = fill2;
         fill2:
            nextState = fill3;
         fill3:
            nextState = fill4;
         fill4:
            nextState = fill5;
         fill5:
            nextState = access;
         // original read or write against the fresh line
         access:
            nextState = finish;
         finish:
            nextState = idle;
         default:
            nextState = idle;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (rst)
         state <= idle;
      else
         state <= nextState;
   end

   // request fields held for the whole sequence
   always_ff @(posedge clk)
   begin
      if (accept)
      begin
         lineAddr  <= addr;
         heldData  <= dataIn;
         heldWay   <= missWay;
         heldWrite <= wr;
      end
   end

   // no stray start, the sequence only begins from a missing valid request
   property stayIdleUnlessMiss;
      @(posedge clk) disable iff (rst)
         (state == idle && !(reqValid && !hit)) |=> (state == idle);
   endproperty
   assert property (stayIdleUnlessMiss)
      else $error("sequencer left idle without a valid miss");

   // finish is a single cycle and always returns to idle
   property finishToIdle;
      @(posedge clk) disable iff (rst)
         (state == finish) |=> (state == idle);
   endproperty
   assert property (finishToIdle)
      else $error("finish not followed by idle");

endmodule

// File: hw/cachePortMux.sv
/* cache port mux, result stage
   turns the sequencer step into memory bus, word select, data and way commands */
`timescale 1ns/1ps

module cachePortMux (
   input  logic                   rd,
   input  logic                   wr,
   input  logic                   stall,
   input  cacheCtrlPkg::addrT     addr,
   input  cacheCtrlPkg::dataT     dataIn,
   input  logic                   hit,
   input  logic                   hitWay,
   input  cacheCtrlPkg::seqStateT state,
   input  cacheCtrlPkg::addrT     lineAddr,
   input  cacheCtrlPkg::dataT     heldData,
   input  logic                   heldWay,
   input  logic                   heldWrite,
   input  cacheCtrlPkg::tagT      victimTag,
   input  cacheCtrlPkg::dataT     cacheDataOut,
   input  cacheCtrlPkg::dataT     memDataOut,
   output logic                   done,
   output cacheCtrlPkg::wayCmdT   wayCmd0,
   output cacheCtrlPkg::wayCmdT   wayCmd1,
   output cacheCtrlPkg::wordSelT  wordSel,
   output cacheCtrlPkg::dataT     cacheDataIn,
   output cacheCtrlPkg::memCmdT   mem
);

   import cacheCtrlPkg::*;

   logic       reqValid;
   logic [3:0] stepNum;
   wordSelT    bank;
   addrT       wbAddr;
   addrT       fillAddr;
   wayCmdT     cmd;
   logic       cmdWay;

   assign reqValid = (rd ^ wr) & ~stall;

   // wb0..wb3 and fill0..fill3 map onto banks 0..3
   assign stepNum = state - 4'd1;
   assign bank    = stepNum[1:0];

   // writeback targets the old line, fill the requested one
   assign wbAddr   = makeAddr(victimTag, indexOf(lineAddr), bank);
   assign fillAddr = makeAddr(tagOf(lineAddr), indexOf(lineAddr), bank);

   always_comb
   begin
      cmd         = '0;
      cmdWay      = heldWay;
      done        = 1'b0;
      wordSel     = wordOf(lineAddr);
      cacheDataIn = heldData;
      mem         = '0;
      unique case (state)
         idle:
         begin
            // in idle this is the hit way, or the victim on a miss
            cmdWay      = hitWay;
            cacheDataIn = dataIn;
            wordSel     = (reqValid && !hit) ? 2'd0 : wordOf(addr);
            if (reqValid)
            begin
               // a miss pre-reads word 0 of the victim for a writeback
               cmd.enable = 1'b1;
               cmd.comp   = hit;
               cmd.write  = hit & wr;
               done       = hit;
            end
         end
         wb0, wb1, wb2, wb3:
         begin
            // read runs one word ahead, word 3 left the cache in wb2
            cmd.enable = (state != wb3);
            wordSel    = bank + 2'd1;
            mem.write  = 1'b1;
            mem.addr   = wbAddr;
            mem.wrData = cacheDataOut;
         end
         fill0, fill1:
         begin
            mem.read = 1'b1;
            mem.addr = fillAddr;
         end
         fill2, fill3, fill4, fill5:
         begin
            if (state inside {fill2, fill3})
            begin
               mem.read = 1'b1;
               mem.addr = fillAddr;
            end
            // bank read two steps back lands in the cache now
            cmd.enable  = 1'b1;
            cmd.write   = 1'b1;
            wordSel     = bank + 2'd2;
            cacheDataIn = memDataOut;
         end
         access:
         begin
            cmd.enable = 1'b1;
            cmd.comp   = 1'b1;
            cmd.write  = heldWrite;
         end
         finish:
            done = 1'b1;
         default:
            done = 1'b0;
      endcase
   end

   // steer the command to the selected way only
   always_comb
   begin
      wayCmd0 = '0;
      wayCmd1 = '0;
      if (cmdWay)
         wayCmd1 = cmd;
      else
         wayCmd0 = cmd;
   end

   always_comb
   begin
      assert final (!(mem.read && mem.write))
         else $error("memory read and write asserted together");
   end

endmodule

// File: hw/cacheCtrl.sv
/* two-way set-associative cache miss controller
   decode, execute and result stages between the cache ways and banked memory */
`timescale 1ns/1ps

module cacheCtrl (
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    rd,
   input  logic                    wr,
   input  cacheCtrlPkg::addrT      addr,
   input  cacheCtrlPkg::dataT      dataIn,
   input  logic                    stall,
   input  logic                    victimWay,
   input  cacheCtrlPkg::wayStatusT wayStat0,
   input  cacheCtrlPkg::wayStatusT wayStat1,
   input  cacheCtrlPkg::dataT      cacheDataOut,
   input  cacheCtrlPkg::dataT      memDataOut,
   output logic                    done,
   output cacheCtrlPkg::wayCmdT    wayCmd0,
   output cacheCtrlPkg::wayCmdT    wayCmd1,
   output cacheCtrlPkg::wordSelT   wordSel,
   output cacheCtrlPkg::dataT      cacheDataIn,
   output cacheCtrlPkg::memCmdT    mem
);

   import cacheCtrlPkg::*;

   logic     hit;
   logic     hitWay;
   logic     missWay;
   logic     dirtyMiss;
   logic     idleWay;
   seqStateT state;
   addrT     lineAddr;
   dataT     heldData;
   logic     heldWay;
   logic     heldWrite;
   tagT      victimTag;

   // idle access goes to the hitting way, a miss pre-reads the victim
   assign idleWay = hit ? hitWay : missWay;

   // stored tag of the captured way, the cache still sees the request index
   assign victimTag = heldWay ? wayStat1.tag : wayStat0.tag;

   victimSelect decodeStage (
      .wayStat0  (wayStat0),
      .wayStat1  (wayStat1),
      .victimWay (victimWay),
      .hit       (hit),
      .hitWay    (hitWay),
      .missWay   (missWay),
      .dirtyMiss (dirtyMiss)
   );

   missSequencer execStage (
      .clk       (clk),
      .rst       (rst),
      .rd        (rd),
      .wr        (wr),
      .stall     (stall),
      .addr      (addr),
      .dataIn    (dataIn),
      .hit       (hit),
      .dirtyMiss (dirtyMiss),
      .missWay   (missWay),
      .state     (state),
      .lineAddr  (lineAddr),
      .heldData  (heldData),
      .heldWay   (heldWay),
      .heldWrite (heldWrite)
   );

   cachePortMux resultStage (
      .rd           (rd),
      .wr           (wr),
      .stall        (stall),
      .addr         (addr),
      .dataIn       (dataIn),
      .hit          (hit),
      .hitWay       (idleWay),
      .state        (state),
      .lineAddr     (lineAddr),
      .heldData     (heldData),
      .heldWay      (heldWay),
      .heldWrite    (heldWrite),
      .victimTag    (victimTag),
      .cacheDataOut (cacheDataOut),
      .memDataOut   (memDataOut),
      .done         (done),
      .wayCmd0      (wayCmd0),
      .wayCmd1      (wayCmd1),
      .wordSel      (wordSel),
      .cacheDataIn  (cacheDataIn),
      .mem          (mem)
   );

endmodule

// File: verification/cacheCtrlTb.sv
/* testbench for the cache miss controller
   random requests against way, memory and reference models */
`timescale 1ns/1ps

module cacheCtrlTb;

   import cacheCtrlPkg::*;

   localparam int numRandom = 300;
   localparam int maxStall  = 2;
   // a dirty miss plus its gap cycle takes 14 cycles and stall adds to that
   localparam int watchdogCycles = numRandom * (14 + maxStall) + 60;

   logic      clk;
   logic      rst;
   logic      rd;
   logic      wr;
   addrT      addr;
   dataT      dataIn;
   logic      stall;
   logic      victimWay;
   wayStatusT wayStat0;
   wayStatusT wayStat1;
   dataT      cacheDataOut;
   dataT      memDataOut;
   logic      done;
   wayCmdT    wayCmd0;
   wayCmdT    wayCmd1;
   wordSelT   wordSel;
   dataT      cacheDataIn;
   memCmdT    mem;

   // way and memory state as the DUT sees it
   tagT    tagArr   [0:1][0:255];
   logic   validArr [0:1][0:255];
   logic   dirtyArr [0:1][0:255];
   dataT   lineArr  [0:1][0:255][0:3];
   dataT   memArr   [0:32767];
   memCmdT traffic  [$];

   // reference state moved only by the controller rules
   tagT  refTag   [0:1][0:255];
   logic refValid [0:1][0:255];
   logic refDirty [0:1][0:255];
   dataT refData  [0:1][0:255][0:3];
   dataT refMem   [0:32767];

   int errors;
   int testErrors;
   int testsRun;
   int testsFailed;
   int hitCount;
   int cleanCount;
   int dirtyCount;

   cacheCtrl dut_i (.*);

   initial
   begin
      clk = 1'b0;
      forever
         #10 clk = ~clk;
   end

   // memory contents depend on every address bit
   function automatic dataT memPattern(logic [14:0] wa);
      return ({wa, 1'b1} * 16'h9e37) ^ 16'h3c5a;
   endfunction

   // status of one way for the presented tag and index
   function automatic wayStatusT statusOf(logic w, indexT i, tagT t);
      wayStatusT s;
      s.hit   = (tagArr[w][i] == t);
      s.valid = validArr[w][i];
      s.dirty = dirtyArr[w][i];
      s.tag   = tagArr[w][i];
      return s;
   endfunction

   // cache ways and banked memory
   // commands sampled mid-cycle and applied 1 ns after the edge
   initial
   begin
      wayCmdT      seenCmd;
      wayCmdT      seenCmd0;
      wayCmdT      seenCmd1;
      wordSelT     seenSel;
      dataT        seenData;
      memCmdT      seenBus;
      indexT       seenIdx;
      tagT         seenTag;
      logic        pipeValid;
      logic [14:0] pipeAddr;
      for (int a = 0; a < 32768; a++)
         memArr[a] = memPattern(15'(a));
      for (int w = 0; w < 2; w++)
         for (int i = 0; i < 256; i++)
         begin
            tagArr[w][i]   = '0;
            validArr[w][i] = 1'b0;
            dirtyArr[w][i] = 1'b0;
            for (int b = 0; b < 4; b++)
               lineArr[w][i][b] = '0;
         end
      pipeValid    = 1'b0;
      pipeAddr     = '0;
      cacheDataOut = '0;
      memDataOut   = '0;
      wayStat0     = '0;
      wayStat1     = '0;
      forever
      begin
         @(negedge clk);
         seenCmd0 = wayCmd0;
         seenCmd1 = wayCmd1;
         seenSel  = wordSel;
         seenData = cacheDataIn;
         seenBus  = mem;
         seenIdx  = addr[10:3];
         seenTag  = addr[15:11];
         @(posedge clk);
         #1;
         for (int w = 0; w < 2; w++)
         begin
            seenCmd = (w == 0) ? seenCmd0 : seenCmd1;
            if (seenCmd.enable && seenCmd.write)
            begin
               lineArr[w][seenIdx][seenSel] = seenData;
               if (seenCmd.comp)
                  dirtyArr[w][seenIdx] = 1'b1;
               else
               begin
                  // a fill write installs the tag of the presented address
                  tagArr[w][seenIdx]   = seenTag;
                  validArr[w][seenIdx] = 1'b1;
                  dirtyArr[w][seenIdx] = 1'b0;
               end
            end
            else if (seenCmd.enable)
               cacheDataOut = lineArr[w][seenIdx][seenSel];
         end
         // read data comes back two cycles after the command
         if (pipeValid)
            memDataOut = memArr[pipeAddr];
         pipeValid = seenBus.read;
         pipeAddr  = seenBus.addr[15:1];
         if (seenBus.write)
            memArr[seenBus.addr[15:1]] = seenBus.wrData;
         if (seenBus.read || seenBus.write)
            traffic.push_back(seenBus);
         // status follows the address driven at +2
         #2;
         wayStat0 = statusOf(1'b0, addr[10:3], addr[15:11]);
         wayStat1 = statusOf(1'b1, addr[10:3], addr[15:11]);
      end
   end

   initial
   begin
      repeat (watchdogCycles)
         @(posedge clk);
      $display("timeout: the run did not end within %0d cycles", watchdogCycles);
      $display("TB FAILED");
      $finish;
   end

   task automatic reportError(input string msg);
      errors++;
      testErrors++;
      $display("FAILED t=%0t: %s", $time, msg);
   endtask

   task automatic finishTest(input string name, input string detail);
      testsRun++;
      if (testErrors != 0)
         testsFailed++;
      $display("test %s: %s, %0d errors", name, detail, testErrors);
      testErrors = 0;
   endtask

   // no done, no way command and no memory traffic for n cycles
   task automatic checkQuiet(input int n, input string why);
      for (int c = 0; c < n; c++)
      begin
         @(negedge clk);
         if (done !== 1'b0)
            reportError($sformatf("done %b %s", done, why));
         if (wayCmd0 !== '0 || wayCmd1 !== '0)
            reportError($sformatf("way command %b/%b %s", wayCmd0, wayCmd1, why));
         if (mem.read !== 1'b0 || mem.write !== 1'b0)
            reportError($sformatf("memory read/write %b%b %s", mem.read, mem.write, why));
         @(posedge clk);
         #2;
      end
   endtask

   task automatic compareSet(input indexT i);
      for (int w = 0; w < 2; w++)
      begin
         if (validArr[w][i] != refValid[w][i] || dirtyArr[w][i] != refDirty[w][i])
            reportError($sformatf("set %0d way %0d valid,dirty %b%b, expected %b%b", i, w,
               validArr[w][i], dirtyArr[w][i], refValid[w][i], refDirty[w][i]));
         if (refValid[w][i] && tagArr[w][i] != refTag[w][i])
            reportError($sformatf("set %0d way %0d tag %h, expected %h", i, w,
               tagArr[w][i], refTag[w][i]));
         for (int b = 0; b < 4; b++)
            if (refValid[w][i] && lineArr[w][i][b] != refData[w][i][b])
               reportError($sformatf("set %0d way %0d word %0d is %h, expected %h", i, w, b,
                  lineArr[w][i][b], refData[w][i][b]));
      end
   endtask

   // one request from acceptance to done followed by one idle cycle
   task automatic runRequest(input logic isWrite, input addrT a, input dataT d,
                             input logic vw, input int stallCycles);
      tagT    t;
      tagT    oldTag;
      indexT  i;
      wordSelT w;
      logic   hitRef;
      logic   wayRef;
      logic   dirtyRef;
      dataT   oldLine [0:3];
      dataT   expRead;
      int     expCycles;
      int     expTraffic;
      int     cycles;
      int     startIdx;
      memCmdT got;
      addrT   expAddr;
      t = a[15:11];
      i = a[10:3];
      w = a[2:1];
      // hit on a valid matching way with way 0 first
      hitRef = 1'b1;
      if (refValid[0][i] && refTag[0][i] == t)
         wayRef = 1'b0;
      else if (refValid[1][i] && refTag[1][i] == t)
         wayRef = 1'b1;
      else
      begin
         hitRef = 1'b0;
         // invalid way first and then the victim input
         wayRef = !refValid[0][i] ? 1'b0 : (!refValid[1][i] ? 1'b1 : vw);
      end
      dirtyRef = !hitRef && refValid[wayRef][i] && refDirty[wayRef][i];
      oldTag   = refTag[wayRef][i];
      for (int b = 0; b < 4; b++)
         oldLine[b] = refData[wayRef][i][b];
      expCycles  = hitRef ? 0 : (dirtyRef ? 12 : 8);
      expTraffic = hitRef ? 0 : (dirtyRef ? 8 : 4);
      if (dirtyRef)
         for (int b = 0; b < 4; b++)
            refMem[{oldTag, i, wordSelT'(b)}] = oldLine[b];
      if (!hitRef)
      begin
         for (int b = 0; b < 4; b++)
            refData[wayRef][i][b] = refMem[{t, i, wordSelT'(b)}];
         refTag[wayRef][i]   = t;
         refValid[wayRef][i] = 1'b1;
         refDirty[wayRef][i] = 1'b0;
      end
      if (isWrite)
      begin
         refData[wayRef][i][w] = d;
         refDirty[wayRef][i]   = 1'b1;
      end
      expRead  = refData[wayRef][i][w];
      startIdx = traffic.size();

      rd        = !isWrite;
      wr        = isWrite;
      addr      = a;
      dataIn    = d;
      victimWay = vw;
      stall     = (stallCycles != 0);
      checkQuiet(stallCycles, "under stall");
      stall  = 1'b0;
      cycles = 0;
      @(negedge clk);
      while (!done)
      begin
         @(posedge clk);
         #2;
         cycles++;
         @(negedge clk);
      end
      if (cycles != expCycles)
         reportError($sformatf("done %0d cycles after request to %h, expected %0d",
            cycles, a, expCycles));
      // a miss reads in access so its data is up in the done cycle
      if (!isWrite && !hitRef && cacheDataOut != expRead)
         reportError($sformatf("miss read %h gave %h, expected %h", a, cacheDataOut, expRead));
      @(posedge clk);
      #2;
      rd = 1'b0;
      wr = 1'b0;
      @(negedge clk);
      if (done)
         reportError("done high for more than one cycle");
      if (!isWrite && hitRef && cacheDataOut != expRead)
         reportError($sformatf("hit read %h gave %h, expected %h", a, cacheDataOut, expRead));
      @(posedge clk);
      #2;

      // writeback words in bank order followed by the four fill reads
      if (traffic.size() - startIdx != expTraffic)
         reportError($sformatf("%0d memory commands for %h, expected %0d",
            traffic.size() - startIdx, a, expTraffic));
      else
      begin
         for (int k = 0; k < expTraffic; k++)
         begin
            got = traffic[startIdx + k];
            if (dirtyRef && k < 4)
            begin
               expAddr = {oldTag, i, wordSelT'(k), 1'b0};
               if (!got.write || got.addr != expAddr || got.wrData != oldLine[k])
                  reportError($sformatf("writeback %0d: w%b %h=%h, expected %h=%h", k,
                     got.write, got.addr, got.wrData, expAddr, oldLine[k]));
            end
            else
            begin
               expAddr = {t, i, wordSelT'(k), 1'b0};
               if (!got.read || got.addr != expAddr)
                  reportError($sformatf("fill read %0d: r%b %h, expected %h", k,
                     got.read, got.addr, expAddr));
            end
         end
      end
      if (!hitRef && !(validArr[wayRef][i] && tagArr[wayRef][i] == t))
         reportError($sformatf("line %h not filled into way %0d", a, wayRef));
      compareSet(i);
      if (dirtyRef)
         for (int b = 0; b < 4; b++)
            if (memArr[{oldTag, i, wordSelT'(b)}] != refMem[{oldTag, i, wordSelT'(b)}])
               reportError($sformatf("victim word %0d in memory is %h, expected %h", b,
                  memArr[{oldTag, i, wordSelT'(b)}], refMem[{oldTag, i, wordSelT'(b)}]));
      if (hitRef)
         hitCount++;
      else if (dirtyRef)
         dirtyCount++;
      else
         cleanCount++;
   endtask

   // stalled requests and a double strobe are never taken
   task automatic stallTest();
      int startIdx;
      startIdx = traffic.size();
      addr  = {5'd9, 8'd200, 2'd1, 1'b0};
      rd    = 1'b1;
      stall = 1'b1;
      checkQuiet(4, "on a stalled read");
      rd = 1'b0;
      wr = 1'b1;
      checkQuiet(3, "on a stalled write");
      rd    = 1'b1;
      stall = 1'b0;
      checkQuiet(3, "with rd and wr both high");
      rd = 1'b0;
      wr = 1'b0;
      checkQuiet(1, "after the stall test");
      if (traffic.size() != startIdx)
         reportError("memory traffic seen during the stall test");
      compareSet(8'd200);
      finishTest("stall", "3 blocked requests");
   endtask

   // a read miss cut off by reset in fill0 must not go on to fill the line
   task automatic resetDuringMiss();
      addr = {5'd9, 8'd200, 2'd1, 1'b0};
      rd   = 1'b1;
      wr   = 1'b0;
      @(posedge clk);
      #2;
      rd  = 1'b0;
      rst = 1'b1;
      // still fill0 until the reset edge, so bank 0 is being read
      @(negedge clk);
      if (mem.read !== 1'b1 || mem.addr !== {5'd9, 8'd200, 2'd0, 1'b0})
         reportError($sformatf("no fill read before the reset, read %b addr %h",
            mem.read, mem.addr));
      repeat (3)
      begin
         @(posedge clk);
         #2;
      end
      rst = 1'b0;
      checkQuiet(10, "after a reset during a miss");
      compareSet(8'd200);
      finishTest("reset during miss", "read miss cut off in fill0");
   endtask

   task automatic randomTraffic();
      addrT a;
      int   stallCycles;
      for (int n = 0; n < numRandom; n++)
      begin
         // few tags and sets so hits and evictions both come up often
         a = {tagT'($urandom_range(0, 3)), indexT'($urandom_range(0, 3) * 37),
              wordSelT'($urandom_range(0, 3)), ($urandom_range(0, 1) == 1)};
         stallCycles = ($urandom_range(0, 7) == 0) ? $urandom_range(1, maxStall) : 0;
         runRequest(($urandom_range(0, 1) == 1), a, dataT'($urandom),
                    ($urandom_range(0, 1) == 1), stallCycles);
      end
      finishTest("random", $sformatf("%0d requests, %0d hits, %0d clean, %0d dirty",
         numRandom, hitCount, cleanCount, dirtyCount));
   endtask

   initial
   begin
      void'($urandom(32'hecdf_599d));
      errors      = 0;
      testErrors  = 0;
      testsRun    = 0;
      testsFailed = 0;
      hitCount    = 0;
      cleanCount  = 0;
      dirtyCount  = 0;
      rst         = 1'b1;
      rd          = 1'b0;
      wr          = 1'b0;
      addr        = '0;
      dataIn      = '0;
      stall       = 1'b0;
      victimWay   = 1'b0;
      for (int a = 0; a < 32768; a++)
         refMem[a] = memPattern(15'(a));
      for (int w = 0; w < 2; w++)
         for (int i = 0; i < 256; i++)
         begin
            refTag[w][i]   = '0;
            refValid[w][i] = 1'b0;
            refDirty[w][i] = 1'b0;
            for (int b = 0; b < 4; b++)
               refData[w][i][b] = '0;
         end
      repeat (3)
         @(posedge clk);
      #2;
      rst = 1'b0;
      checkQuiet(2, "after reset");
      finishTest("reset", "command outputs idle");
      stallTest();
      resetDuringMiss();
      randomTraffic();
      $display("summary: %0d tests, %0d failed, %0d errors", testsRun, testsFailed, errors);
      if (errors == 0)
         $display("TB PASSED");
      else
         $display("TB FAILED");
      $finish;
   end

endmodule

// File: files.f
hw/cacheCtrlPkg.sv
hw/victimSelect.sv
hw/missSequencer.sv
hw/cachePortMux.sv
hw/cacheCtrl.sv
verification/cacheCtrlTb.sv

// File: Makefile
# Verilator flow for the cache miss controller
TOP = cacheCtrlTb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f files.f --top-module $(TOP)

# pass only when the run prints the pass line
sim:
	verilator --binary --timing --assert -j 0 -f files.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "^TB PASSED$$"

clean:
	rm -rf obj_dir
